// File: csrAddrPkg.sv
// Machine CSR address map

package csrAddrPkg;

  // Register width, fixed for RV32
  localparam int Xlen = 32;

  // Machine CSR addresses
  typedef enum logic [11:0] {
    CsrMvendorid     = 12'hF11,
    CsrMarchid       = 12'hF12,
    CsrMimpid        = 12'hF13,
    CsrMhartid       = 12'hF14,
    CsrMstatus       = 12'h300,
    CsrMisa          = 12'h301,
    CsrMedeleg       = 12'h302,
    CsrMideleg       = 12'h303,
    CsrMie           = 12'h304,
    CsrMtvec         = 12'h305,
    CsrMcounteren    = 12'h306,
    CsrMstatush      = 12'h310,
    CsrMcountinhibit = 12'h320,
    CsrMscratch      = 12'h340,
    CsrMepc          = 12'h341,
    CsrMcause        = 12'h342,
    CsrMtval         = 12'h343,
    CsrMip           = 12'h344,
    CsrPmpcfg0       = 12'h3A0,
    CsrPmpaddr0      = 12'h3B0
  } csrAddrE;

  // PMP address windows, sized for the largest supported bank
  localparam int MaxPmpEntries = 16;
  localparam logic [11:0] PmpCfgLast  = 12'(CsrPmpcfg0 + MaxPmpEntries / 4 - 1);
  localparam logic [11:0] PmpAddrLast = 12'(CsrPmpaddr0 + MaxPmpEntries - 1);

  // Exception 11 (ecall from M) is never delegated
  localparam logic [Xlen-1:0] MedelegMask = ~(Xlen'(1) << 11);
  // Only supervisor interrupts are delegable
  localparam logic [11:0] MidelegMask = 12'h222;

  // Extension letters I (bit 8), M (12), S (18), U (20)
  localparam logic [25:0] MisaExtensions = 26'h0141100;
  localparam logic [Xlen-1:0] MisaValue = {2'b01, 4'b0000, MisaExtensions};
  localparam logic [Xlen-1:0] MimpidValue = 32'h100;

endpackage

// File: csrTypesPkg.sv
// CSR command and PMP types

package csrTypesPkg;

  // CSR write command from the memory stage
  typedef struct packed {
    logic                enable;
    logic                validNotFlushed;
    csrAddrPkg::csrAddrE addr;
    logic [31:0]         data;
  } csrWriteT;

  // Trap report, loads mepc / mcause / mtval
  typedef struct packed {
    logic        taken;
    logic [31:0] nextEpc;
    logic [31:0] nextCause;
    logic [31:0] nextTval;
  } trapT;

  // One PMP configuration byte, msb first
  typedef struct packed {
    logic       lock;
    logic [1:0] reserved;
    logic [1:0] addrMode;
    logic       x;
    logic       w;
    logic       r;
  } pmpCfgT;

  // Top-of-range address matching mode
  localparam logic [1:0] PmpModeTor = 2'b01;

endpackage

// File: csrDecode.sv
// CSR write strobe decoder

`timescale 1ns/100ps

module csrDecode #(
  parameter int PmpEntries = 8
) (
  input  csrTypesPkg::csrWriteT  csrWrite,
  output logic                   writeMtvec,
  output logic                   writeMedeleg,
  output logic                   writeMideleg,
  output logic                   writeMscratch,
  output logic                   writeMepc,
  output logic                   writeMcause,
  output logic                   writeMtval,
  output logic                   writeMcounteren,
  output logic                   writeMcountinhibit,
  output logic [PmpEntries-1:0]  cfgHit,
  output logic [PmpEntries-1:0]  addrHit,
  output logic                   writeMstatus,
  output logic                   illegalWriteReadonly
);

  import csrAddrPkg::*;

  // Write qualified by the pipeline
  logic       writeOk;
  // Address falls inside a PMP window
  logic       inCfgRange;
  logic       inAddrRange;
  // Offset into each PMP window
  logic [1:0] cfgIdx;
  logic [3:0] addrIdx;

  assign writeOk = csrWrite.enable & csrWrite.validNotFlushed;

  //////////////////////////////
  // Named registers
  //////////////////////////////

  assign writeMstatus       = writeOk & (csrWrite.addr == CsrMstatus);
  assign writeMtvec         = writeOk & (csrWrite.addr == CsrMtvec);
  assign writeMedeleg       = writeOk & (csrWrite.addr == CsrMedeleg);
  assign writeMideleg       = writeOk & (csrWrite.addr == CsrMideleg);
  assign writeMscratch      = writeOk & (csrWrite.addr == CsrMscratch);
  assign writeMepc          = writeOk & (csrWrite.addr == CsrMepc);
  assign writeMcause        = writeOk & (csrWrite.addr == CsrMcause);
  assign writeMtval         = writeOk & (csrWrite.addr == CsrMtval);
  assign writeMcounteren    = writeOk & (csrWrite.addr == CsrMcounteren);
  assign writeMcountinhibit = writeOk & (csrWrite.addr == CsrMcountinhibit);

  // ID registers are read-only
  // Flagged even for a flushed instruction
  assign illegalWriteReadonly = csrWrite.enable &
    (csrWrite.addr inside {CsrMvendorid, CsrMarchid, CsrMimpid, CsrMhartid});

  //////////////////////////////
  // PMP entries
  //////////////////////////////

  assign inCfgRange  = (csrWrite.addr >= CsrPmpcfg0) && (csrWrite.addr <= PmpCfgLast);
  assign inAddrRange = (csrWrite.addr >= CsrPmpaddr0) && (csrWrite.addr <= PmpAddrLast);
  assign cfgIdx      = 2'(csrWrite.addr - CsrPmpcfg0);
  assign addrIdx     = 4'(csrWrite.addr - CsrPmpaddr0);

  // pmpcfg n covers entries 4n..4n+3
  // Lock bits are applied inside each entry
  for (genvar i = 0; i < PmpEntries; i++) begin : gHit
    assign cfgHit[i]  = writeOk & inCfgRange & (cfgIdx == 2'(i / 4));
    assign addrHit[i] = writeOk & inAddrRange & (addrIdx == 4'(i));
  end

endmodule

// File: pmpEntry.sv
// Single PMP entry

`timescale 1ns/100ps

module pmpEntry (
  input  logic                clk,
  input  logic                reset,
  input  logic                cfgHit,
  input  logic                addrHit,
  input  csrTypesPkg::pmpCfgT cfgData,
  input  logic [31:0]         addrData,
  input  csrTypesPkg::pmpCfgT nextCfg,
  output csrTypesPkg::pmpCfgT cfg,
  output logic [31:0]         addr
);

  import csrTypesPkg::*;

  logic cfgLocked;
  logic nextTorLocked;
  logic addrLocked;

  // A locked byte stays until reset
  assign cfgLocked = cfg.lock;

  // Locked TOR neighbour uses our address as its lower bound
  assign nextTorLocked = nextCfg.lock & (nextCfg.addrMode == PmpModeTor);
  assign addrLocked    = cfg.lock | nextTorLocked;

  // Configuration byte
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg <= '0;
    end else if (cfgHit & ~cfgLocked) begin
      cfg          <= cfgData;
      // Reserved field reads as zero
      cfg.reserved <= 2'b00;
    end
  end

  // Address register
  always_ff @(posedge clk) begin
    if (reset) begin
      addr <= '0;
    end else if (addrHit & ~addrLocked) begin
      addr <= addrData;
    end
  end

endmodule

// File: machineCsrs.sv
// Machine trap setup and handling registers

`timescale 1ns/100ps

module machineCsrs (
  input  logic               clk,
  input  logic               reset,
  input  logic               writeMtvec,
  input  logic               writeMedeleg,
  input  logic               writeMideleg,
  input  logic               writeMscratch,
  input  logic               writeMepc,
  input  logic               writeMcause,
  input  logic               writeMtval,
  input  logic               writeMcounteren,
  input  logic               writeMcountinhibit,
  input  logic [31:0]        wdata,
  input  csrTypesPkg::trapT  trap,
  output logic [31:0]        mtvec,
  output logic [31:0]        medeleg,
  output logic [31:0]        mscratch,
  output logic [31:0]        mepc,
  output logic [31:0]        mcause,
  output logic [31:0]        mtval,
  output logic [11:0]        mideleg,
  output logic [31:0]        mcounteren,
  output logic [31:0]        mcountinhibit
);

  import csrAddrPkg::*;

  // Write values after WARL masking
  logic [Xlen-1:0] mtvecNext;
  logic [Xlen-1:0] medelegNext;
  logic [11:0]     midelegNext;

  // Mode field bit 1 is reserved, only direct and vectored remain
  assign mtvecNext   = {wdata[Xlen-1:2], 1'b0, wdata[0]};
  assign medelegNext = wdata & MedelegMask;
  assign midelegNext = wdata[11:0] & MidelegMask;

  //////////////////////////////
  // Setup registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvec         <= '0;
      medeleg       <= '0;
      mideleg       <= '0;
      mscratch      <= '0;
      mcounteren    <= '0;
      mcountinhibit <= '0;
    end else begin
      if (writeMtvec)         mtvec         <= mtvecNext;
      if (writeMedeleg)       medeleg       <= medelegNext;
      if (writeMideleg)       mideleg       <= midelegNext;
      if (writeMscratch)      mscratch      <= wdata;
      // Counter controls keep every bit
      if (writeMcounteren)    mcounteren    <= wdata;
      if (writeMcountinhibit) mcountinhibit <= wdata;
    end
  end

  //////////////////////////////
  // Trap handling registers
  //////////////////////////////

  // Trap loads all three regardless of valid
  // and overrides a CSR write in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (trap.taken) begin
      mepc   <= trap.nextEpc;
      mcause <= trap.nextCause;
      mtval  <= trap.nextTval;
    end else begin
      if (writeMepc)   mepc   <= wdata;
      if (writeMcause) mcause <= wdata;
      if (writeMtval)  mtval  <= wdata;
    end
  end

endmodule

// File: csrReadMux.sv
// Machine CSR read multiplexer

`timescale 1ns/100ps

module csrReadMux #(
  parameter int PmpEntries = 8
) (
  input  csrAddrPkg::csrAddrE  addr,
  input  logic [31:0]          mtvec,
  input  logic [31:0]          medeleg,
  input  logic [11:0]          mideleg,
  input  logic [31:0]          mscratch,
  input  logic [31:0]          mepc,
  input  logic [31:0]          mcause,
  input  logic [31:0]          mtval,
  input  logic [31:0]          mcounteren,
  input  logic [31:0]          mcountinhibit,
  input  csrTypesPkg::pmpCfgT  pmpCfg [PmpEntries-1:0],
  input  logic [31:0]          pmpAddr [PmpEntries-1:0],
  input  logic [31:0]          mstatus,
  input  logic [11:0]          mip,
  input  logic [11:0]          mie,
  output logic [31:0]          readVal,
  output logic                 illegalAccess
);

  import csrAddrPkg::*;

  logic            inCfgRange;
  logic            inAddrRange;
  logic [1:0]      cfgIdx;
  logic [3:0]      addrIdx;
  // Four config bytes per pmpcfg word
  logic [31:0]     cfgWord [PmpEntries/4-1:0];
  logic [Xlen-1:0] cfgSel;
  logic [Xlen-1:0] addrSel;
  logic            cfgMatch;
  logic            addrMatch;

  assign inCfgRange  = (addr >= CsrPmpcfg0) && (addr <= PmpCfgLast);
  assign inAddrRange = (addr >= CsrPmpaddr0) && (addr <= PmpAddrLast);
  assign cfgIdx      = 2'(addr - CsrPmpcfg0);
  assign addrIdx     = 4'(addr - CsrPmpaddr0);

  // Entry 4n sits in the low byte
  for (genvar g = 0; g < PmpEntries / 4; g++) begin : gPack
    assign cfgWord[g] = {pmpCfg[4*g+3], pmpCfg[4*g+2], pmpCfg[4*g+1], pmpCfg[4*g]};
  end

  //////////////////////////////
  // PMP selection
  //////////////////////////////

  // Only implemented entries match, the rest fall to illegal
  always_comb begin
    cfgSel    = '0;
    cfgMatch  = 1'b0;
    addrSel   = '0;
    addrMatch = 1'b0;
    for (int g = 0; g < PmpEntries / 4; g++) begin
      if (inCfgRange && (cfgIdx == 2'(g))) begin
        cfgSel   = cfgWord[g];
        cfgMatch = 1'b1;
      end
    end
    for (int g = 0; g < PmpEntries; g++) begin
      if (inAddrRange && (addrIdx == 4'(g))) begin
        addrSel   = pmpAddr[g];
        addrMatch = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Final read value
  //////////////////////////////

  always_comb begin
    readVal       = '0;
    illegalAccess = 1'b0;
    if (addrMatch) begin
      readVal = addrSel;
    end else if (cfgMatch) begin
      readVal = cfgSel;
    end else begin
      case (addr)
        CsrMisa:          readVal = MisaValue;
        CsrMimpid:        readVal = MimpidValue;
        // Vendor, arch, hart ID and mstatush read zero
        CsrMvendorid,
        CsrMarchid,
        CsrMhartid,
        CsrMstatush:      readVal = '0;
        CsrMstatus:       readVal = mstatus;
        CsrMtvec:         readVal = mtvec;
        CsrMedeleg:       readVal = medeleg;
        CsrMideleg:       readVal = {{(Xlen-12){1'b0}}, mideleg};
        CsrMip:           readVal = {{(Xlen-12){1'b0}}, mip};
        CsrMie:           readVal = {{(Xlen-12){1'b0}}, mie};
        CsrMscratch:      readVal = mscratch;
        CsrMepc:          readVal = mepc;
        CsrMcause:        readVal = mcause;
        CsrMtval:         readVal = mtval;
        CsrMcounteren:    readVal = mcounteren;
        CsrMcountinhibit: readVal = mcountinhibit;
        default:          illegalAccess = 1'b1;
      endcase
    end
  end

endmodule

// File: csrm.sv
// Machine-mode CSR block

`timescale 1ns/100ps

module csrm #(
  parameter int PmpEntries = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  csrTypesPkg::csrWriteT csrWrite,
  input  csrTypesPkg::trapT     trap,
  // Owned by the privilege unit, read only here
  input  logic [31:0]           mstatus,
  input  logic [11:0]           mip,
  input  logic [11:0]           mie,
  output logic [31:0]           readVal,
  output logic [31:0]           mtvec,
  output logic [31:0]           mepc,
  output logic [31:0]           medeleg,
  output logic [11:0]           mideleg,
  output logic [31:0]           mcounteren,
  output logic [31:0]           mcountinhibit,
  output csrTypesPkg::pmpCfgT   pmpCfg [PmpEntries-1:0],
  output logic [31:0]           pmpAddr [PmpEntries-1:0],
  output logic                  writeMstatus,
  output logic                  illegalAccess,
  output logic                  illegalWriteReadonly
);

  import csrTypesPkg::*;

  logic writeMtvec, writeMedeleg, writeMideleg, writeMscratch;
  logic writeMepc, writeMcause, writeMtval;
  logic writeMcounteren, writeMcountinhibit;
  logic [PmpEntries-1:0] cfgHit;
  logic [PmpEntries-1:0] addrHit;
  // Registers visible only through reads
  logic [31:0] mscratch, mcause, mtval;
  // Neighbour config for the TOR lock
  pmpCfgT nextCfg [PmpEntries-1:0];

  csrDecode #(.PmpEntries(PmpEntries)) decode0 (
    .csrWrite, .writeMtvec, .writeMedeleg, .writeMideleg, .writeMscratch,
    .writeMepc, .writeMcause, .writeMtval, .writeMcounteren, .writeMcountinhibit,
    .cfgHit, .addrHit, .writeMstatus, .illegalWriteReadonly
  );

  machineCsrs regs0 (
    .clk, .reset, .writeMtvec, .writeMedeleg, .writeMideleg, .writeMscratch,
    .writeMepc, .writeMcause, .writeMtval, .writeMcounteren, .writeMcountinhibit,
    .wdata(csrWrite.data), .trap, .mtvec, .medeleg, .mscratch, .mepc, .mcause,
    .mtval, .mideleg, .mcounteren, .mcountinhibit
  );

  //////////////////////////////
  // PMP bank
  //////////////////////////////

  for (genvar i = 0; i < PmpEntries; i++) begin : gPmp
    pmpCfgT cfgByte;

    // Byte lane i%4 of the pmpcfg word
    assign cfgByte = csrWrite.data[8*(i%4) +: 8];

    // Last entry has no neighbour above it
    if (i == PmpEntries - 1) begin : gLast
      assign nextCfg[i] = '0;
    end else begin : gChain
      assign nextCfg[i] = pmpCfg[i+1];
    end

    pmpEntry entry (
      .clk, .reset, .cfgHit(cfgHit[i]), .addrHit(addrHit[i]), .cfgData(cfgByte),
      .addrData(csrWrite.data), .nextCfg(nextCfg[i]), .cfg(pmpCfg[i]), .addr(pmpAddr[i])
    );
  end

  csrReadMux #(.PmpEntries(PmpEntries)) readMux0 (
    .addr(csrWrite.addr), .mtvec, .medeleg, .mideleg, .mscratch, .mepc, .mcause,
    .mtval, .mcounteren, .mcountinhibit, .pmpCfg, .pmpAddr, .mstatus, .mip, .mie,
    .readVal, .illegalAccess
  );

endmodule

// File: csrClockGen.sv
// Testbench clock and reset

`timescale 1ns/100ps

module csrClockGen #(
  parameter int PeriodNs    = 10,
  parameter int ResetCycles = 5
) (
  output logic clk,
  output logic reset
);

  // Free-running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  // Reset held over the first rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// File: csrmTb.sv
// Machine CSR block testbench

`timescale 1ns/100ps

module csrmTb;

  import csrAddrPkg::*;
  import csrTypesPkg::*;

  localparam int PmpEntries  = 8;
  localparam int ClkPeriod   = 10;
  localparam int ResetCycles = 5;
  // Extra cycles allowed beyond the vector count
  localparam int MarginCycles = 20;

  // One line of the golden file
  typedef struct packed {
    logic        en;
    logic        vld;
    logic        trp;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] epc;
    logic [31:0] cause;
    logic [31:0] tval;
    logic        chk;
    logic [31:0] expRead;
    logic [2:0]  expFlags;
  } vecT;

  logic        clk;
  logic        reset;
  csrWriteT    csrWrite;
  trapT        trap;
  logic [31:0] mstatus;
  logic [11:0] mip;
  logic [11:0] mie;
  logic [31:0] readVal;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] medeleg;
  logic [11:0] mideleg;
  logic [31:0] mcounteren;
  logic [31:0] mcountinhibit;
  pmpCfgT      pmpCfg [PmpEntries-1:0];
  logic [31:0] pmpAddr [PmpEntries-1:0];
  logic        writeMstatus;
  logic        illegalAccess;
  logic        illegalWriteReadonly;

  vecT vecs[$];
  int  mismatches;
  int  otherErrors;
  bit  loaded;

  csrClockGen #(.PeriodNs(ClkPeriod), .ResetCycles(ResetCycles)) clkGen0 (
    .clk, .reset
  );

  csrm #(.PmpEntries(PmpEntries)) dut0 (
    .clk, .reset, .csrWrite, .trap, .mstatus, .mip, .mie, .readVal, .mtvec, .mepc,
    .medeleg, .mideleg, .mcounteren, .mcountinhibit, .pmpCfg, .pmpAddr,
    .writeMstatus, .illegalAccess, .illegalWriteReadonly
  );

  //////////////////////////////
  // Golden file
  //////////////////////////////

  // Lines that do not parse into all columns are skipped
  task automatic loadGolden();
    int          fd;
    int          n;
    string       line;
    logic        en;
    logic        vld;
    logic        trp;
    logic        chk;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] epc;
    logic [31:0] cause;
    logic [31:0] tval;
    logic [31:0] expRead;
    logic [2:0]  expFlags;
    fd = $fopen("csrGolden.txt", "r");
    if (fd == 0) begin
      $display("Could not open csrGolden.txt for reading");
      otherErrors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", en, vld, trp, addr, data,
                  epc, cause, tval, chk, expRead, expFlags);
      if (n == 11) begin
        vecs.push_back({en, vld, trp, addr, data, epc, cause, tval, chk, expRead, expFlags});
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // Drive and check
  //////////////////////////////

  task automatic applyVec(vecT v);
    csrWrite.enable          = v.en;
    csrWrite.validNotFlushed = v.vld;
    csrWrite.addr            = csrAddrE'(v.addr);
    csrWrite.data            = v.data;
    trap.taken               = v.trp;
    trap.nextEpc             = v.epc;
    trap.nextCause           = v.cause;
    trap.nextTval            = v.tval;
  endtask

  // Outputs are combinational and sampled just before the rising edge
  task automatic checkVec(vecT v);
    if (readVal !== v.expRead) begin
      $display("Mismatch at %0t: readVal (addr %h) expected %h, actual %h",
               $time, v.addr, v.expRead, readVal);
      mismatches++;
    end
    if (illegalAccess !== v.expFlags[2]) begin
      $display("Mismatch at %0t: illegalAccess expected %b, actual %b",
               $time, v.expFlags[2], illegalAccess);
      mismatches++;
    end
    if (illegalWriteReadonly !== v.expFlags[1]) begin
      $display("Mismatch at %0t: illegalWriteReadonly expected %b, actual %b",
               $time, v.expFlags[1], illegalWriteReadonly);
      mismatches++;
    end
    if (writeMstatus !== v.expFlags[0]) begin
      $display("Mismatch at %0t: writeMstatus expected %b, actual %b",
               $time, v.expFlags[0], writeMstatus);
      mismatches++;
    end
  endtask

  // Register ports must show the same value as a read of their address
  task automatic compareRegPorts(vecT v);
    logic [31:0] portVal;
    string       portName;
    int          idx;
    portVal  = '0;
    portName = "";
    case (v.addr)
      CsrMtvec: begin
        portName = "mtvec";
        portVal  = mtvec;
      end
      CsrMepc: begin
        portName = "mepc";
        portVal  = mepc;
      end
      CsrMedeleg: begin
        portName = "medeleg";
        portVal  = medeleg;
      end
      CsrMideleg: begin
        portName = "mideleg";
        portVal  = {20'h0, mideleg};
      end
      CsrMcounteren: begin
        portName = "mcounteren";
        portVal  = mcounteren;
      end
      CsrMcountinhibit: begin
        portName = "mcountinhibit";
        portVal  = mcountinhibit;
      end
      default: ;
    endcase
    // PMP address registers, one per entry
    idx = int'(v.addr) - int'(CsrPmpaddr0);
    if (idx >= 0 && idx < PmpEntries) begin
      portName = $sformatf("pmpAddr[%0d]", idx);
      portVal  = pmpAddr[idx];
    end
    // Config bytes, entry 4n in the low byte
    idx = int'(v.addr) - int'(CsrPmpcfg0);
    if (idx >= 0 && idx < PmpEntries / 4) begin
      portName = $sformatf("pmpCfg[%0d:%0d]", 4 * idx + 3, 4 * idx);
      portVal  = {pmpCfg[4*idx+3], pmpCfg[4*idx+2], pmpCfg[4*idx+1], pmpCfg[4*idx]};
    end
    if (portName != "" && portVal !== v.expRead) begin
      $display("Mismatch at %0t: %s expected %h, actual %h",
               $time, portName, v.expRead, portVal);
      mismatches++;
    end
  endtask

  task automatic reportCounts();
    $display("Mismatches: %0d, other errors: %0d", mismatches, otherErrors);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    vecT v;
    csrWrite    = '0;
    trap        = '0;
    // Levels owned by the rest of the core
    mstatus     = 32'h00001808;
    mip         = 12'h080;
    mie         = 12'h888;
    mismatches  = 0;
    otherErrors = 0;
    loadGolden();
    if (vecs.size() == 0) begin
      $display("No test vectors were read from the golden file");
      otherErrors++;
    end
    loaded = 1'b1;
    wait (reset === 1'b0);
    foreach (vecs[i]) begin
      v = vecs[i];
      @(negedge clk);
      applyVec(v);
      #(ClkPeriod / 2 - 1);
      if (v.chk) begin
        checkVec(v);
        compareRegPorts(v);
      end
    end
    // Return to idle
    @(negedge clk);
    csrWrite = '0;
    trap     = '0;
    reportCounts();
    if (mismatches == 0 && otherErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    int limitNs;
    wait (loaded);
    limitNs = (vecs.size() + ResetCycles + MarginCycles) * ClkPeriod;
    #(limitNs);
    $display("Timeout, the test did not finish within %0d ns", limitNs);
    otherErrors++;
    reportCounts();
    $display("Something failed");
    $finish;
  end

endmodule

// File: csrGolden.txt
// en vld trp addr data epc cause tval chk expRead expFlags (all hex)
// expFlags bit 2 illegalAccess, bit 1 illegalWriteReadonly, bit 0 writeMstatus
0 0 0 305 00000000 00000000 00000000 00000000 1 00000000 0
0 0 0 341 00000000 00000000 00000000 00000000 1 00000000 0
0 0 0 3B0 00000000 00000000 00000000 00000000 1 00000000 0
0 0 0 301 00000000 00000000 00000000 00000000 1 40141100 0
0 0 0 F13 00000000 00000000 00000000 00000000 1 00000100 0
0 0 0 F11 00000000 00000000 00000000 00000000 1 00000000 0
0 0 0 F14 00000000 00000000 00000000 00000000 1 00000000 0
1 1 0 340 DEADBEEF 00000000 00000000 00000000 0 00000000 0
0 0 0 340 00000000 00000000 00000000 00000000 1 DEADBEEF 0
1 1 0 306 FFFFFFFF 00000000 00000000 00000000 0 00000000 0
0 0 0 306 00000000 00000000 00000000 00000000 1 FFFFFFFF 0
1 1 0 320 A5A5A5A5 00000000 00000000 00000000 0 00000000 0
0 0 0 320 00000000 00000000 00000000 00000000 1 A5A5A5A5 0
1 1 0 305 12345677 00000000 00000000 00000000 0 00000000 0
0 0 0 305 00000000 00000000 00000000 00000000 1 12345675 0
1 1 0 302 FFFFFFFF 00000000 00000000 00000000 0 00000000 0
0 0 0 302 00000000 00000000 00000000 00000000 1 FFFFF7FF 0
1 1 0 303 FFFFFFFF 00000000 00000000 00000000 0 00000000 0
0 0 0 303 00000000 00000000 00000000 00000000 1 00000222 0
1 0 0 340 11111111 00000000 00000000 00000000 0 00000000 0
0 0 0 340 00000000 00000000 00000000 00000000 1 DEADBEEF 0
1 1 1 341 AAAAAAAA 80000100 00000002 0000BEEF 0 00000000 0
0 0 0 341 00000000 00000000 00000000 00000000 1 80000100 0
0 0 0 342 00000000 00000000 00000000 00000000 1 00000002 0
0 0 0 343 00000000 00000000 00000000 00000000 1 0000BEEF 0
1 1 0 3A0 1F0B0903 00000000 00000000 00000000 0 00000000 0
0 0 0 3A0 00000000 00000000 00000000 00000000 1 1F0B0903 0
1 1 0 3B0 20000000 00000000 00000000 00000000 0 00000000 0
1 1 0 3B1 20000400 00000000 00000000 00000000 0 00000000 0
0 0 0 3B0 00000000 00000000 00000000 00000000 1 20000000 0
1 1 0 3A0 1F0B0983 00000000 00000000 00000000 0 00000000 0
1 1 0 3A0 01020304 00000000 00000000 00000000 0 00000000 0
0 0 0 3A0 00000000 00000000 00000000 00000000 1 01020383 0
1 1 0 3B0 33333333 00000000 00000000 00000000 0 00000000 0
0 0 0 3B0 00000000 00000000 00000000 00000000 1 20000000 0
1 1 0 3A0 01890300 00000000 00000000 00000000 0 00000000 0
1 1 0 3B1 44444444 00000000 00000000 00000000 0 00000000 0
0 0 0 3B1 00000000 00000000 00000000 00000000 1 20000400 0
0 0 0 7C0 00000000 00000000 00000000 00000000 1 00000000 4
1 1 0 F14 00000001 00000000 00000000 00000000 1 00000000 2
1 1 0 300 00000008 00000000 00000000 00000000 1 00001808 1
0 0 0 344 00000000 00000000 00000000 00000000 1 00000080 0
0 0 0 304 00000000 00000000 00000000 00000000 1 00000888 0

// File: files.f
csrAddrPkg.sv
csrTypesPkg.sv
csrDecode.sv
pmpEntry.sv
machineCsrs.sv
csrReadMux.sv
csrm.sv
csrClockGen.sv
csrmTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the CSR block testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -j 0 --top-module csrmTb -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VcsrmTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

# Verdict comes from the log
if grep -q "Something failed" "$logFile"; then
  exit 1
fi
exit 0
